/* common/fsa_pkg.sv */
`default_nettype none

package fsa_pkg;

	localparam int PIXEL_W = 8;
	localparam int IMG_HW = 12;
	localparam int IMG_WW = 12;

	// travels with each pixel through stages 0 to 3
	typedef struct packed {
		logic [PIXEL_W-1:0] pixel;
		logic [IMG_WW-1:0] x;
		logic [IMG_HW-1:0] y;
		logic first_col;
		logic last_col;
		logic first_row;
		logic last_row;
		logic frame_last;
		logic valid;
	} pix_ctl_t;

	// one column's state as kept in the column memory
	typedef struct packed {
		logic black;
		logic val_outer;
		logic [IMG_HW-1:0] top_outer;
		logic [IMG_HW-1:0] bot_outer;
		logic val_inner;
		logic [IMG_HW-1:0] top_inner;
		logic [IMG_HW-1:0] bot_inner;
	} col_state_t;

	typedef struct packed {
		logic any_outer;
		logic [IMG_WW-1:0] x_min;
		logic [IMG_WW-1:0] x_max;
		logic [IMG_HW-1:0] y_min;
		logic [IMG_HW-1:0] y_max;
		logic [IMG_WW:0] inner_cols;
	} frame_sum_t;

endpackage

`default_nettype wire

/* fsa_core/fsa_col_update.sv */
`timescale 1ns/1ps
`default_nettype none

module fsa_col_update #(
	parameter int PIXEL_W = fsa_pkg::PIXEL_W,
	parameter int IMG_WW = fsa_pkg::IMG_WW
) (
	input wire clk,
	input wire resetn,
	input wire [PIXEL_W-1:0] i_ref,
	input wire fsa_pkg::pix_ctl_t i_ctl,
	input wire fsa_pkg::col_state_t i_rd_state,
	output logic o_wr_en,
	output logic [IMG_WW-1:0] o_wr_addr,
	output fsa_pkg::col_state_t o_wr_state,
	output logic o_wr_last_row,
	output logic o_wr_frame_end
);

	fsa_pkg::pix_ctl_t s3_ctl;
	logic s3_black;
	fsa_pkg::col_state_t s3_rd;
	fsa_pkg::col_state_t nxt;

	// stage 3 thresholds the pixel and border rows never count as black
	always_ff @(posedge clk) begin
		if (!resetn) begin
			s3_ctl <= '0;
			s3_black <= 1'b0;
		end else begin
			s3_ctl <= i_ctl;
			s3_black <= !(i_ctl.first_row || i_ctl.last_row) && (i_ctl.pixel < i_ref);
		end
	end

	// read data lands together with the stage 3 word
	always_ff @(posedge clk) begin
		s3_rd <= i_rd_state;
	end

	always_comb begin
		if (s3_ctl.first_row) begin
			// old frame's state is discarded
			nxt = '0;
			nxt.black = s3_black;
			if (s3_black) begin
				nxt.val_outer = 1'b1;
				nxt.bot_outer = s3_ctl.y;
			end
		end else begin
			nxt = s3_rd;
			nxt.black = s3_black;
			if (s3_black) begin
				nxt.val_outer = 1'b1;
				nxt.bot_outer = s3_ctl.y;
				if (!s3_rd.val_outer)
					nxt.top_outer = s3_ctl.y;
				// black again after a gap in the outer span
				if (s3_rd.val_outer && !s3_rd.black) begin
					nxt.val_inner = 1'b1;
					nxt.bot_inner = s3_ctl.y;
				end
				if (s3_rd.black && !s3_rd.val_inner)
					nxt.top_inner = s3_ctl.y;
			end
		end
	end

	// stage 4 writes the new state back
	always_ff @(posedge clk) begin
		if (!resetn) begin
			o_wr_en <= 1'b0;
			o_wr_last_row <= 1'b0;
			o_wr_frame_end <= 1'b0;
		end else begin
			o_wr_en <= s3_ctl.valid;
			o_wr_last_row <= s3_ctl.valid & s3_ctl.last_row;
			o_wr_frame_end <= s3_ctl.valid & s3_ctl.frame_last;
		end
	end

	always_ff @(posedge clk) begin
		if (s3_ctl.valid) begin
			o_wr_addr <= s3_ctl.x;
			o_wr_state <= nxt;
		end
	end

endmodule

`default_nettype wire

/* fsa_core/fsa_pos_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fsa_pos_stage #(
	parameter int PIXEL_W = fsa_pkg::PIXEL_W,
	parameter int IMG_HW = fsa_pkg::IMG_HW,
	parameter int IMG_WW = fsa_pkg::IMG_WW
) (
	input wire clk,
	input wire resetn,
	input wire i_valid,
	input wire [PIXEL_W-1:0] i_data,
	input wire i_sof,
	input wire i_eol,
	input wire [IMG_HW-1:0] i_height,
	output logic o_rd_en,
	output logic [IMG_WW-1:0] o_rd_addr,
	output fsa_pkg::pix_ctl_t o_ctl
);

	fsa_pkg::pix_ctl_t s0;
	fsa_pkg::pix_ctl_t s1;
	logic [IMG_HW-1:0] height_m1;

	assign height_m1 = i_height - 1'b1;

	// stage 0 holds the position counters
	always_ff @(posedge clk) begin
		if (!resetn) begin
			s0 <= '0;
		end else if (i_valid) begin
			s0.valid <= 1'b1;
			s0.pixel <= i_data;
			s0.last_col <= i_eol;
			s0.last_row <= 1'b0;
			s0.frame_last <= 1'b0;
			// s0.last_col still holds the previous beat's eol here
			if (i_sof || s0.last_col) begin
				s0.x <= '0;
				s0.first_col <= 1'b1;
			end else begin
				s0.x <= s0.x + 1'b1;
				s0.first_col <= 1'b0;
			end
			if (i_sof) begin
				s0.y <= '0;
				s0.first_row <= 1'b1;
			end else if (s0.last_col) begin
				s0.y <= s0.y + 1'b1;
				s0.first_row <= 1'b0;
			end
		end else begin
			s0.valid <= 1'b0;
		end
	end

	// column read goes out straight from stage 0
	assign o_rd_en = s0.valid;
	assign o_rd_addr = s0.x;

	// stage 1 adds the last row flag
	always_ff @(posedge clk) begin
		if (!resetn) begin
			s1 <= '0;
		end else begin
			s1 <= s0;
			s1.last_row <= (s0.y == height_m1);
		end
	end

	// stage 2 marks the last pixel of the frame
	always_ff @(posedge clk) begin
		if (!resetn) begin
			o_ctl <= '0;
		end else begin
			o_ctl <= s1;
			o_ctl.frame_last <= s1.last_col & s1.last_row;
		end
	end

endmodule

`default_nettype wire

/* hw/fsa_col_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module fsa_col_ram #(
	parameter int IMG_WW = fsa_pkg::IMG_WW
) (
	input wire clk,
	input wire i_rd_en,
	input wire [IMG_WW-1:0] i_rd_addr,
	output fsa_pkg::col_state_t o_rd_state,
	input wire i_wr_en,
	input wire [IMG_WW-1:0] i_wr_addr,
	input wire fsa_pkg::col_state_t i_wr_state
);

	fsa_pkg::col_state_t mem [0:(1 << IMG_WW)-1];
	fsa_pkg::col_state_t rd_q;

	always_ff @(posedge clk) begin
		if (i_wr_en)
			mem[i_wr_addr] <= i_wr_state;
	end

	// two register stages on the read side
	always_ff @(posedge clk) begin
		if (i_rd_en)
			rd_q <= mem[i_rd_addr];
		o_rd_state <= rd_q;
	end

endmodule

`default_nettype wire

/* hw/fsa_result.sv */
`timescale 1ns/1ps
`default_nettype none

module fsa_result #(
	parameter int IMG_WW = fsa_pkg::IMG_WW
) (
	input wire clk,
	input wire resetn,
	input wire i_wr_en,
	input wire [IMG_WW-1:0] i_wr_addr,
	input wire fsa_pkg::col_state_t i_wr_state,
	input wire i_wr_last_row,
	input wire i_wr_frame_end,
	output logic o_sum_valid,
	output fsa_pkg::frame_sum_t o_sum
);

	fsa_pkg::frame_sum_t run;
	fsa_pkg::frame_sum_t fold;

	// running summary with the current column folded in
	always_comb begin
		fold = run;
		if (i_wr_state.val_outer) begin
			fold.any_outer = 1'b1;
			// columns arrive in ascending order
			fold.x_max = i_wr_addr;
			if (!run.any_outer) begin
				fold.x_min = i_wr_addr;
				fold.y_min = i_wr_state.top_outer;
				fold.y_max = i_wr_state.bot_outer;
			end else begin
				if (i_wr_state.top_outer < run.y_min)
					fold.y_min = i_wr_state.top_outer;
				if (i_wr_state.bot_outer > run.y_max)
					fold.y_max = i_wr_state.bot_outer;
			end
		end
		if (i_wr_state.val_inner)
			fold.inner_cols = run.inner_cols + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			run <= '0;
			o_sum_valid <= 1'b0;
		end else begin
			o_sum_valid <= i_wr_en & i_wr_frame_end;
			if (i_wr_en && i_wr_frame_end)
				run <= '0;
			else if (i_wr_en && i_wr_last_row)
				run <= fold;
		end
	end

	always_ff @(posedge clk) begin
		if (i_wr_en && i_wr_frame_end)
			o_sum <= fold;
	end

endmodule

`default_nettype wire

/* hw/fsa_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fsa_top #(
	parameter int PIXEL_W = fsa_pkg::PIXEL_W,
	parameter int IMG_HW = fsa_pkg::IMG_HW,
	parameter int IMG_WW = fsa_pkg::IMG_WW
) (
	input wire clk,
	input wire resetn,
	input wire i_valid,
	input wire [PIXEL_W-1:0] i_data,
	input wire i_sof,
	input wire i_eol,
	input wire [IMG_HW-1:0] i_height,
	input wire [PIXEL_W-1:0] i_ref,
	output wire o_ready,
	output wire o_sum_valid,
	output fsa_pkg::frame_sum_t o_sum
);

	logic rd_en;
	logic [IMG_WW-1:0] rd_addr;
	fsa_pkg::col_state_t rd_state;
	fsa_pkg::pix_ctl_t ctl;
	logic wr_en;
	logic [IMG_WW-1:0] wr_addr;
	fsa_pkg::col_state_t wr_state;
	logic wr_last_row;
	logic wr_frame_end;

	// no back-pressure
	assign o_ready = 1'b1;

	fsa_pos_stage #(
		.PIXEL_W(PIXEL_W),
		.IMG_HW(IMG_HW),
		.IMG_WW(IMG_WW)
	) u_pos (
		.clk(clk),
		.resetn(resetn),
		.i_valid(i_valid),
		.i_data(i_data),
		.i_sof(i_sof),
		.i_eol(i_eol),
		.i_height(i_height),
		.o_rd_en(rd_en),
		.o_rd_addr(rd_addr),
		.o_ctl(ctl)
	);

	fsa_col_update #(
		.PIXEL_W(PIXEL_W),
		.IMG_WW(IMG_WW)
	) u_update (
		.clk(clk),
		.resetn(resetn),
		.i_ref(i_ref),
		.i_ctl(ctl),
		.i_rd_state(rd_state),
		.o_wr_en(wr_en),
		.o_wr_addr(wr_addr),
		.o_wr_state(wr_state),
		.o_wr_last_row(wr_last_row),
		.o_wr_frame_end(wr_frame_end)
	);

	fsa_col_ram #(
		.IMG_WW(IMG_WW)
	) u_ram (
		.clk(clk),
		.i_rd_en(rd_en),
		.i_rd_addr(rd_addr),
		.o_rd_state(rd_state),
		.i_wr_en(wr_en),
		.i_wr_addr(wr_addr),
		.i_wr_state(wr_state)
	);

	fsa_result #(
		.IMG_WW(IMG_WW)
	) u_result (
		.clk(clk),
		.resetn(resetn),
		.i_wr_en(wr_en),
		.i_wr_addr(wr_addr),
		.i_wr_state(wr_state),
		.i_wr_last_row(wr_last_row),
		.i_wr_frame_end(wr_frame_end),
		.o_sum_valid(o_sum_valid),
		.o_sum(o_sum)
	);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
set -e -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_fsa_top -f src.f -o tb_fsa_top
./obj_dir/tb_fsa_top | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
	echo "simulation run ok"
else
	echo "simulation run reported errors"
	exit 1
fi

/* sim/tb_fsa_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fsa_top;

	localparam int PW = fsa_pkg::PIXEL_W;
	localparam int HW = fsa_pkg::IMG_HW;
	localparam int WW = fsa_pkg::IMG_WW;
	localparam int MAX_W = 20;
	localparam int MAX_H = 16;
	localparam int SUM_TIMEOUT = 200;

	logic clk = 1'b0;
	logic resetn;
	logic i_valid;
	logic [PW-1:0] i_data;
	logic i_sof;
	logic i_eol;
	logic [HW-1:0] i_height;
	logic [PW-1:0] i_ref;
	wire o_ready;
	wire o_sum_valid;
	fsa_pkg::frame_sum_t o_sum;

	logic [PW-1:0] img [0:MAX_H-1][0:MAX_W-1];
	logic [31:0] rng;
	int cyc = 0;
	int last_cyc;
	int errs;
	int pass_cnt;
	int fail_cnt;
	fsa_pkg::frame_sum_t got_q[$];
	int cyc_q[$];

	fsa_top #(
		.PIXEL_W(PW),
		.IMG_HW(HW),
		.IMG_WW(WW)
	) u_fsa_top (
		.clk(clk),
		.resetn(resetn),
		.i_valid(i_valid),
		.i_data(i_data),
		.i_sof(i_sof),
		.i_eol(i_eol),
		.i_height(i_height),
		.i_ref(i_ref),
		.o_ready(o_ready),
		.o_sum_valid(o_sum_valid),
		.o_sum(o_sum)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	// collect every summary with the cycle it showed up in
	always @(negedge clk) begin
		if (o_sum_valid) begin
			got_q.push_back(o_sum);
			cyc_q.push_back(cyc);
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] v;
		v = s ^ (s << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	function automatic fsa_pkg::frame_sum_t make_sum(input int a, input int x0, input int x1,
			input int y0, input int y1, input int n);
		fsa_pkg::frame_sum_t s;
		s = '0;
		s.any_outer = (a != 0);
		s.x_min = WW'(x0);
		s.x_max = WW'(x1);
		s.y_min = HW'(y0);
		s.y_max = HW'(y1);
		s.inner_cols = (WW+1)'(n);
		return s;
	endfunction

	// expected summary worked out column by column
	function automatic fsa_pkg::frame_sum_t model_frame(input int w, input int h,
			input logic [PW-1:0] lvl);
		int x, y, top, bot, found, xmin, xmax, ymin, ymax, cnt;
		logic blk, above, vo, vi;
		found = 0;
		xmin = 0;
		xmax = 0;
		ymin = 0;
		ymax = 0;
		cnt = 0;
		for (x = 0; x < w; x++) begin
			above = 1'b0;
			vo = 1'b0;
			vi = 1'b0;
			top = 0;
			bot = 0;
			// first and last rows never count as black
			for (y = 1; y < h - 1; y++) begin
				blk = img[y][x] < lvl;
				if (blk) begin
					if (!vo)
						top = y;
					// black back after a gap
					if (vo && !above)
						vi = 1'b1;
					vo = 1'b1;
					bot = y;
				end
				above = blk;
			end
			if (vo) begin
				if (found == 0 || top < ymin)
					ymin = top;
				if (found == 0 || bot > ymax)
					ymax = bot;
				if (found == 0)
					xmin = x;
				xmax = x;
				found = 1;
			end
			if (vi)
				cnt++;
		end
		return make_sum(found, xmin, xmax, ymin, ymax, cnt);
	endfunction

	task automatic fill_image(input logic [PW-1:0] v);
		int x, y;
		for (y = 0; y < MAX_H; y++)
			for (x = 0; x < MAX_W; x++)
				img[y][x] = v;
	endtask

	task automatic draw_rect(input int x0, input int y0, input int x1, input int y1,
			input logic [PW-1:0] v);
		int x, y;
		for (y = y0; y <= y1; y++)
			for (x = x0; x <= x1; x++)
				img[y][x] = v;
	endtask

	task automatic send_frame(input int w, input int h, input logic gaps);
		int x, y, n;
		for (y = 0; y < h; y++) begin
			for (x = 0; x < w; x++) begin
				n = 0;
				if (gaps) begin
					rng = xorshift32(rng);
					if (rng[3:0] < 4'd4)
						n = int'(rng[5:4]) + 1;
				end
				if (n > 0) begin
					i_valid = 1'b0;
					i_sof = 1'b0;
					i_eol = 1'b0;
					repeat (n) @(negedge clk);
				end
				i_valid = 1'b1;
				i_data = img[y][x];
				i_sof = (x == 0 && y == 0);
				i_eol = (x == w - 1);
				@(negedge clk);
			end
		end
		i_valid = 1'b0;
		i_sof = 1'b0;
		i_eol = 1'b0;
		last_cyc = cyc;
	endtask

	task automatic wait_sums(input int n);
		int k;
		k = 0;
		while (got_q.size() < n && k < SUM_TIMEOUT) begin
			@(negedge clk);
			k++;
		end
		if (got_q.size() < n) begin
			$display("timeout: only %0d of %0d frame summaries arrived within %0d cycles",
				got_q.size(), n, SUM_TIMEOUT);
			errs++;
		end else if (got_q.size() > n) begin
			$display("more frame summaries arrived than frames were sent");
			errs++;
		end
	endtask

	task automatic check_field(input string name, input int e, input int g);
		assert (g == e) else begin
			$display("FAILED %s expected %h got %h", name, e, g);
			errs++;
		end
	endtask

	task automatic check_sum(input fsa_pkg::frame_sum_t e, input fsa_pkg::frame_sum_t g);
		check_field("o_sum.any_outer", 32'(e.any_outer), 32'(g.any_outer));
		check_field("o_sum.x_min", 32'(e.x_min), 32'(g.x_min));
		check_field("o_sum.x_max", 32'(e.x_max), 32'(g.x_max));
		check_field("o_sum.y_min", 32'(e.y_min), 32'(g.y_min));
		check_field("o_sum.y_max", 32'(e.y_max), 32'(g.y_max));
		check_field("o_sum.inner_cols", 32'(e.inner_cols), 32'(g.inner_cols));
	endtask

	// waits for one frame's summary and returns the cycle it was seen in
	task automatic expect_sum(input fsa_pkg::frame_sum_t e, output int sc);
		sc = 0;
		wait_sums(1);
		if (got_q.size() > 0) begin
			check_sum(e, got_q[0]);
			sc = cyc_q[0];
		end
		got_q.delete();
		cyc_q.delete();
	endtask

	task automatic close_test(input string name, input int e0);
		got_q.delete();
		cyc_q.delete();
		if (errs == e0) begin
			pass_cnt++;
			$display("%s: ok", name);
		end else begin
			fail_cnt++;
			$display("%s: %0d errors", name, errs - e0);
		end
	endtask

	task automatic solid_rect();
		int e0, sc;
		e0 = errs;
		i_height = HW'(10);
		i_ref = 8'h80;
		fill_image(8'hc0);
		draw_rect(3, 2, 11, 6, 8'h20);
		send_frame(16, 10, 1'b0);
		expect_sum(make_sum(1, 3, 11, 2, 6, 0), sc);
		check_field("o_sum_valid latency", 5, sc - last_cyc);
		check_field("o_ready", 1, 32'(o_ready));
		close_test("solid rectangle", e0);
	endtask

	task automatic border_rows();
		int e0, sc;
		e0 = errs;
		fill_image(8'hc0);
		draw_rect(0, 0, 15, 0, 8'h10);
		draw_rect(0, 9, 15, 9, 8'h10);
		send_frame(16, 10, 1'b1);
		expect_sum(make_sum(0, 0, 0, 0, 0, 0), sc);
		close_test("border rows", e0);
	endtask

	task automatic hollow_ring();
		int e0, sc;
		e0 = errs;
		fill_image(8'hc0);
		draw_rect(2, 1, 13, 8, 8'h20);
		draw_rect(4, 3, 11, 6, 8'hc0);
		send_frame(16, 10, 1'b0);
		// columns 4 to 11 cross both the top and the bottom edge
		expect_sum(make_sum(1, 2, 13, 1, 8, 8), sc);
		close_test("hollow ring", e0);
	endtask

	task automatic threshold_edge();
		int e0, sc;
		e0 = errs;
		fill_image(8'hc0);
		draw_rect(2, 2, 6, 5, 8'h40);
		img[7][10] = 8'h80;
		send_frame(16, 10, 1'b0);
		expect_sum(make_sum(1, 2, 6, 2, 5, 0), sc);
		img[7][10] = 8'h7f;
		send_frame(16, 10, 1'b0);
		expect_sum(make_sum(1, 2, 10, 2, 7, 0), sc);
		close_test("threshold", e0);
	endtask

	task automatic random_frames();
		fsa_pkg::frame_sum_t exp_q[$];
		int e0, f, w, x, y;
		e0 = errs;
		i_height = HW'(12);
		i_ref = 8'h70;
		for (f = 0; f < 6; f++) begin
			rng = xorshift32(rng);
			w = 5 + rng % 12;
			for (y = 0; y < 12; y++) begin
				for (x = 0; x < w; x++) begin
					rng = xorshift32(rng);
					img[y][x] = rng[PW-1:0];
				end
			end
			exp_q.push_back(model_frame(w, 12, i_ref));
			send_frame(w, 12, 1'b1);
		end
		wait_sums(6);
		if (got_q.size() == 6) begin
			for (f = 0; f < 6; f++)
				check_sum(exp_q[f], got_q[f]);
		end
		close_test("back-to-back random frames", e0);
	endtask

	initial begin
		resetn = 1'b0;
		i_valid = 1'b0;
		i_data = '0;
		i_sof = 1'b0;
		i_eol = 1'b0;
		i_height = HW'(10);
		i_ref = 8'h80;
		rng = 32'hc1c2_8c96;
		errs = 0;
		pass_cnt = 0;
		fail_cnt = 0;
		repeat (10) @(negedge clk);
		resetn = 1'b1;
		@(negedge clk);
		solid_rect();
		border_rows();
		hollow_ring();
		threshold_edge();
		random_frames();
		$display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && errs == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
common/fsa_pkg.sv
hw/fsa_col_ram.sv
fsa_core/fsa_pos_stage.sv
fsa_core/fsa_col_update.sv
hw/fsa_result.sv
hw/fsa_top.sv
sim/tb_fsa_top.sv
